// ==== logic/dispatch_config.svh ====
`ifndef DISPATCH_CONFIG_SVH
`define DISPATCH_CONFIG_SVH

// Rename slots offered per cycle
`define DIS_WIDTH   2

// Register and index widths
`define PREG_W      5
`define PREG_NUM    32
`define ROB_W       6
`define LQ_W        4
`define SQ_W        4
`define OP_W        20

// Queue depths and port counts
`define INT_DEPTH   8
`define MEM_DEPTH   8
`define WAKEUP_NUM  2
`define BUSY_RD_NUM 5

`endif

// ==== logic/dispatch_pkg.sv ====
`default_nettype none

`include "dispatch_config.svh"

package dispatch_pkg;

    typedef logic [`PREG_W-1:0] preg_t;
    typedef logic [`ROB_W-1:0]  rob_idx_t;
    typedef logic [`LQ_W-1:0]   lq_idx_t;
    typedef logic [`SQ_W-1:0]   sq_idx_t;

    localparam int INTOP_W   = 4;
    localparam int IMM_W     = `OP_W - INTOP_W;
    localparam int MEMOP_W   = 3;
    localparam int OFFSET_W  = 12;
    localparam int MEM_PAD_W = `OP_W - MEMOP_W - OFFSET_W;

    typedef struct packed {
        logic [INTOP_W-1:0] intop;
        logic [IMM_W-1:0]   imm;
    } int_view_t;

    // Top bit of memop marks a store
    typedef struct packed {
        logic [MEMOP_W-1:0]   memop;
        logic [OFFSET_W-1:0]  offset;
        logic [MEM_PAD_W-1:0] unused;
    } mem_view_t;

    typedef union packed {
        int_view_t int_view;
        mem_view_t mem_view;
    } op_word_u;

    typedef struct packed {
        rob_idx_t           robidx;
        preg_t              prs1;
        preg_t              prs2;
        preg_t              prd;
        logic               we;
        logic [INTOP_W-1:0] intop;
        logic [IMM_W-1:0]   imm;
    } int_entry_t;

    typedef struct packed {
        rob_idx_t            robidx;
        preg_t               prs1;
        preg_t               prs2;
        preg_t               prd;
        logic                we;
        logic [MEMOP_W-1:0]  memop;
        logic [OFFSET_W-1:0] offset;
        lq_idx_t             lq_idx;
        sq_idx_t             sq_idx;
    } mem_entry_t;

endpackage

`default_nettype wire

// ==== logic/dispatch_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "dispatch_config.svh"

module dispatch_ctrl (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          flush_i,
    input  dispatch_pkg::lq_idx_t                         lq_restore_i,
    input  dispatch_pkg::sq_idx_t                         sq_restore_i,
    input  logic [`DIS_WIDTH-1:0]                         rename_valid_i,
    input  logic [`DIS_WIDTH-1:0]                         rename_mem_i,
    input  logic [`DIS_WIDTH-1:0]                         rename_we_i,
    input  dispatch_pkg::op_word_u [`DIS_WIDTH-1:0]       rename_op_i,
    input  dispatch_pkg::preg_t [`DIS_WIDTH-1:0]          rename_prs1_i,
    input  dispatch_pkg::preg_t [`DIS_WIDTH-1:0]          rename_prs2_i,
    input  dispatch_pkg::preg_t [`DIS_WIDTH-1:0]          rename_prd_i,
    input  dispatch_pkg::rob_idx_t [`DIS_WIDTH-1:0]       rename_robidx_i,
    input  logic [$clog2(`INT_DEPTH+1)-1:0]               int_free_i,
    input  logic [$clog2(`MEM_DEPTH+1)-1:0]               load_free_i,
    input  logic [$clog2(`MEM_DEPTH+1)-1:0]               store_free_i,
    output logic                                          full_o,
    output logic [`DIS_WIDTH-1:0]                         int_enq_o,
    output dispatch_pkg::int_entry_t [`DIS_WIDTH-1:0]     int_enq_data_o,
    output logic [`DIS_WIDTH-1:0]                         load_enq_o,
    output logic [`DIS_WIDTH-1:0]                         store_enq_o,
    output dispatch_pkg::mem_entry_t [`DIS_WIDTH-1:0]     load_enq_data_o,
    output dispatch_pkg::mem_entry_t [`DIS_WIDTH-1:0]     store_enq_data_o,
    output logic [`DIS_WIDTH-1:0]                         set_en_o,
    output dispatch_pkg::preg_t [`DIS_WIDTH-1:0]          set_preg_o
);
    import dispatch_pkg::*;

    lq_idx_t               lq_tail;
    lq_idx_t               lq_tail_n;
    sq_idx_t               sq_tail;
    sq_idx_t               sq_tail_n;
    logic [`DIS_WIDTH-1:0] slot_ok;
    logic [`DIS_WIDTH-1:0] is_store;
    mem_entry_t [`DIS_WIDTH-1:0] mem_entry;

    // Any queue that cannot take a whole group stalls rename
    assign full_o = (int_free_i < `DIS_WIDTH) || (load_free_i < `DIS_WIDTH) ||
                    (store_free_i < `DIS_WIDTH);

    // **********************************************************************
    // Decode and steer with slot 0 oldest
    // **********************************************************************
    always_comb begin
        lq_idx_t lq_cur;
        sq_idx_t sq_cur;
        lq_cur = lq_tail;
        sq_cur = sq_tail;
        for (int i = 0; i < `DIS_WIDTH; i++) begin
            slot_ok[i]  = rename_valid_i[i] & ~full_o & ~flush_i;
            is_store[i] = rename_op_i[i].mem_view.memop[MEMOP_W-1];

            int_enq_o[i]   = slot_ok[i] & ~rename_mem_i[i];
            load_enq_o[i]  = slot_ok[i] & rename_mem_i[i] & ~is_store[i];
            store_enq_o[i] = slot_ok[i] & rename_mem_i[i] & is_store[i];

            int_enq_data_o[i] = '{robidx: rename_robidx_i[i], prs1: rename_prs1_i[i],
                                  prs2: rename_prs2_i[i], prd: rename_prd_i[i],
                                  we: rename_we_i[i],
                                  intop: rename_op_i[i].int_view.intop,
                                  imm: rename_op_i[i].int_view.imm};

            // Indices count the loads and stores ahead of this slot
            mem_entry[i] = '{robidx: rename_robidx_i[i], prs1: rename_prs1_i[i],
                             prs2: rename_prs2_i[i], prd: rename_prd_i[i],
                             we: rename_we_i[i],
                             memop: rename_op_i[i].mem_view.memop,
                             offset: rename_op_i[i].mem_view.offset,
                             lq_idx: lq_cur, sq_idx: sq_cur};
            lq_cur = lq_cur + lq_idx_t'(load_enq_o[i]);
            sq_cur = sq_cur + sq_idx_t'(store_enq_o[i]);

            set_en_o[i]   = slot_ok[i] & rename_we_i[i];
            set_preg_o[i] = rename_prd_i[i];
        end
        lq_tail_n = lq_cur;
        sq_tail_n = sq_cur;
    end

    assign load_enq_data_o  = mem_entry;
    assign store_enq_data_o = mem_entry;

    // Tails wrap modulo the queue size
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lq_tail <= '0;
            sq_tail <= '0;
        end else if (flush_i) begin
            lq_tail <= lq_restore_i;
            sq_tail <= sq_restore_i;
        end else begin
            lq_tail <= lq_tail_n;
            sq_tail <= sq_tail_n;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dispatch_queue.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "dispatch_config.svh"

module dispatch_queue #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 8
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              flush_i,
    input  logic [`DIS_WIDTH-1:0]             enq_i,
    input  logic [`DIS_WIDTH-1:0][DATA_W-1:0] enq_data_i,
    input  logic                              issue_full_i,
    output logic [$clog2(DEPTH+1)-1:0]        free_o,
    output logic                              issue_valid_o,
    output logic [DATA_W-1:0]                 issue_data_o
);
    // Pointers wrap on their own width, so DEPTH is a power of two
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  head;
    logic [PTR_W-1:0]  tail;
    logic [CNT_W-1:0]  count;
    logic [PTR_W-1:0]  wr_ptr [`DIS_WIDTH];
    logic [CNT_W-1:0]  enq_num;
    logic              pop;

    // Valid slots are packed behind the tail in slot order
    always_comb begin
        enq_num = '0;
        for (int i = 0; i < `DIS_WIDTH; i++) begin
            wr_ptr[i] = tail + PTR_W'(enq_num);
            enq_num   = enq_num + CNT_W'(enq_i[i]);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `DIS_WIDTH; i++) begin
            if (enq_i[i]) begin
                mem[wr_ptr[i]] <= enq_data_i[i];
            end
        end
    end

    // **********************************************************************
    // Pointers and occupancy
    // **********************************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            tail <= tail + PTR_W'(enq_num);
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + enq_num - CNT_W'(pop);
        end
    end

    // Head leaves on every edge it is offered
    assign issue_valid_o = (count != '0) && !issue_full_i;
    assign pop           = issue_valid_o;
    assign issue_data_o  = mem[head];
    assign free_o        = CNT_W'(DEPTH) - count;

endmodule

`default_nettype wire

// ==== logic/busy_table.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "dispatch_config.svh"

module busy_table (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [`DIS_WIDTH-1:0]                    set_en_i,
    input  dispatch_pkg::preg_t [`DIS_WIDTH-1:0]     set_preg_i,
    input  logic [`WAKEUP_NUM-1:0]                   wakeup_valid_i,
    input  dispatch_pkg::preg_t [`WAKEUP_NUM-1:0]    wakeup_preg_i,
    input  dispatch_pkg::preg_t [`BUSY_RD_NUM-1:0]   rd_preg_i,
    output logic [`BUSY_RD_NUM-1:0]                  rd_busy_o
);
    logic [`PREG_NUM-1:0] busy_q;
    logic [`PREG_NUM-1:0] busy_d;

    // Clears first so that a same-cycle set wins
    always_comb begin
        busy_d = busy_q;
        for (int w = 0; w < `WAKEUP_NUM; w++) begin
            if (wakeup_valid_i[w]) begin
                busy_d[wakeup_preg_i[w]] = 1'b0;
            end
        end
        for (int s = 0; s < `DIS_WIDTH; s++) begin
            if (set_en_i[s]) begin
                busy_d[set_preg_i[s]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

    // Reads see the registered table only
    for (genvar r = 0; r < `BUSY_RD_NUM; r++) begin : g_rd
        assign rd_busy_o[r] = busy_q[rd_preg_i[r]];
    end

endmodule

`default_nettype wire

// ==== logic/dispatch_top.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "dispatch_config.svh"

module dispatch_top (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [`DIS_WIDTH-1:0]                    rename_valid_i,
    input  logic [`DIS_WIDTH-1:0]                    rename_mem_i,
    input  logic [`DIS_WIDTH-1:0]                    rename_we_i,
    input  dispatch_pkg::op_word_u [`DIS_WIDTH-1:0]  rename_op_i,
    input  dispatch_pkg::preg_t [`DIS_WIDTH-1:0]     rename_prs1_i,
    input  dispatch_pkg::preg_t [`DIS_WIDTH-1:0]     rename_prs2_i,
    input  dispatch_pkg::preg_t [`DIS_WIDTH-1:0]     rename_prd_i,
    input  dispatch_pkg::rob_idx_t [`DIS_WIDTH-1:0]  rename_robidx_i,
    input  logic                                     flush_i,
    input  dispatch_pkg::lq_idx_t                    lq_restore_i,
    input  dispatch_pkg::sq_idx_t                    sq_restore_i,
    input  logic [`WAKEUP_NUM-1:0]                   wakeup_valid_i,
    input  dispatch_pkg::preg_t [`WAKEUP_NUM-1:0]    wakeup_preg_i,
    input  logic                                     int_issue_full_i,
    input  logic                                     load_issue_full_i,
    input  logic                                     store_issue_full_i,
    output logic                                     full_o,
    output logic                                     int_issue_valid_o,
    output dispatch_pkg::int_entry_t                 int_issue_data_o,
    output logic                                     load_issue_valid_o,
    output dispatch_pkg::mem_entry_t                 load_issue_data_o,
    output logic                                     store_issue_valid_o,
    output dispatch_pkg::mem_entry_t                 store_issue_data_o,
    output logic                                     int_rs1_ready_o,
    output logic                                     int_rs2_ready_o,
    output logic                                     load_rs1_ready_o,
    output logic                                     store_rs1_ready_o,
    output logic                                     store_rs2_ready_o
);
    import dispatch_pkg::*;

    localparam int INT_CNT_W = $clog2(`INT_DEPTH + 1);
    localparam int MEM_CNT_W = $clog2(`MEM_DEPTH + 1);

    logic [`DIS_WIDTH-1:0]         int_enq;
    logic [`DIS_WIDTH-1:0]         load_enq;
    logic [`DIS_WIDTH-1:0]         store_enq;
    int_entry_t [`DIS_WIDTH-1:0]   int_enq_data;
    mem_entry_t [`DIS_WIDTH-1:0]   load_enq_data;
    mem_entry_t [`DIS_WIDTH-1:0]   store_enq_data;
    logic [INT_CNT_W-1:0]          int_free;
    logic [MEM_CNT_W-1:0]          load_free;
    logic [MEM_CNT_W-1:0]          store_free;
    logic [`DIS_WIDTH-1:0]         set_en;
    preg_t [`DIS_WIDTH-1:0]        set_preg;
    preg_t [`BUSY_RD_NUM-1:0]      rd_preg;
    logic [`BUSY_RD_NUM-1:0]       rd_busy;

    dispatch_ctrl u_ctrl (
        .clk, .rst, .flush_i, .lq_restore_i, .sq_restore_i,
        .rename_valid_i, .rename_mem_i, .rename_we_i, .rename_op_i,
        .rename_prs1_i, .rename_prs2_i, .rename_prd_i, .rename_robidx_i,
        .int_free_i(int_free), .load_free_i(load_free), .store_free_i(store_free),
        .full_o,
        .int_enq_o(int_enq), .int_enq_data_o(int_enq_data),
        .load_enq_o(load_enq), .store_enq_o(store_enq),
        .load_enq_data_o(load_enq_data), .store_enq_data_o(store_enq_data),
        .set_en_o(set_en), .set_preg_o(set_preg)
    );

    // **********************************************************************
    // Issue queues
    // **********************************************************************
    dispatch_queue #(.DATA_W($bits(int_entry_t)), .DEPTH(`INT_DEPTH)) u_int_queue (
        .clk, .rst, .flush_i, .enq_i(int_enq), .enq_data_i(int_enq_data),
        .issue_full_i(int_issue_full_i), .free_o(int_free),
        .issue_valid_o(int_issue_valid_o), .issue_data_o(int_issue_data_o)
    );

    dispatch_queue #(.DATA_W($bits(mem_entry_t)), .DEPTH(`MEM_DEPTH)) u_load_queue (
        .clk, .rst, .flush_i, .enq_i(load_enq), .enq_data_i(load_enq_data),
        .issue_full_i(load_issue_full_i), .free_o(load_free),
        .issue_valid_o(load_issue_valid_o), .issue_data_o(load_issue_data_o)
    );

    dispatch_queue #(.DATA_W($bits(mem_entry_t)), .DEPTH(`MEM_DEPTH)) u_store_queue (
        .clk, .rst, .flush_i, .enq_i(store_enq), .enq_data_i(store_enq_data),
        .issue_full_i(store_issue_full_i), .free_o(store_free),
        .issue_valid_o(store_issue_valid_o), .issue_data_o(store_issue_data_o)
    );

    // Read port order is int rs1, int rs2, load rs1, store rs1, store rs2
    assign rd_preg = {store_issue_data_o.prs2, store_issue_data_o.prs1,
                      load_issue_data_o.prs1, int_issue_data_o.prs2, int_issue_data_o.prs1};

    busy_table u_busy (
        .clk, .rst, .set_en_i(set_en), .set_preg_i(set_preg),
        .wakeup_valid_i, .wakeup_preg_i,
        .rd_preg_i(rd_preg), .rd_busy_o(rd_busy)
    );

    assign int_rs1_ready_o   = ~rd_busy[0];
    assign int_rs2_ready_o   = ~rd_busy[1];
    assign load_rs1_ready_o  = ~rd_busy[2];
    assign store_rs1_ready_o = ~rd_busy[3];
    assign store_rs2_ready_o = ~rd_busy[4];

endmodule

`default_nettype wire

// ==== sim/dispatch_properties.sv ====
`default_nettype none
`timescale 1ns/10ps

module dispatch_properties (
    input  logic clk,
    input  logic rst,
    input  logic flush_i,
    input  logic full_i,
    input  logic int_valid_i,
    input  logic load_valid_i,
    input  logic store_valid_i,
    input  logic int_issue_full_i,
    input  logic load_issue_full_i,
    input  logic store_issue_full_i
);
    logic any_valid;

    assign any_valid = int_valid_i | load_valid_i | store_valid_i;

    // Queues come out of reset empty
    a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !full_i && !any_valid)
        else $error("full or issue valid high right after reset");

    // **********************************************************************
    // Issue handshake
    // **********************************************************************
    a_int_hold: assert property (@(posedge clk) disable iff (rst)
        !(int_valid_i && int_issue_full_i))
        else $error("int issue valid while int issue unit is full");

    a_load_hold: assert property (@(posedge clk) disable iff (rst)
        !(load_valid_i && load_issue_full_i))
        else $error("load issue valid while load issue unit is full");

    a_store_hold: assert property (@(posedge clk) disable iff (rst)
        !(store_valid_i && store_issue_full_i))
        else $error("store issue valid while store issue unit is full");

    a_flush_empty: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> !any_valid)
        else $error("issue valid in the cycle after a flush");

endmodule

bind dispatch_top dispatch_properties u_props (
    .clk, .rst, .flush_i, .full_i(full_o),
    .int_valid_i(int_issue_valid_o), .load_valid_i(load_issue_valid_o),
    .store_valid_i(store_issue_valid_o),
    .int_issue_full_i, .load_issue_full_i, .store_issue_full_i
);

`default_nettype wire

// ==== sim/dispatch_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "dispatch_config.svh"

module dispatch_tb;
    import dispatch_pkg::*;

    // Cycle budgets of reset and of the four tests
    localparam int CYCLE_BUDGET = 5 + 340 + 30 + 72 + 88;

    logic                          clk;
    logic                          rst;
    logic [`DIS_WIDTH-1:0]         rename_valid_i;
    logic [`DIS_WIDTH-1:0]         rename_mem_i;
    logic [`DIS_WIDTH-1:0]         rename_we_i;
    op_word_u [`DIS_WIDTH-1:0]     rename_op_i;
    preg_t [`DIS_WIDTH-1:0]        rename_prs1_i;
    preg_t [`DIS_WIDTH-1:0]        rename_prs2_i;
    preg_t [`DIS_WIDTH-1:0]        rename_prd_i;
    rob_idx_t [`DIS_WIDTH-1:0]     rename_robidx_i;
    logic                          flush_i;
    lq_idx_t                       lq_restore_i;
    sq_idx_t                       sq_restore_i;
    logic [`WAKEUP_NUM-1:0]        wakeup_valid_i;
    preg_t [`WAKEUP_NUM-1:0]       wakeup_preg_i;
    logic                          int_issue_full_i;
    logic                          load_issue_full_i;
    logic                          store_issue_full_i;
    logic                          full_o;
    logic                          int_issue_valid_o;
    int_entry_t                    int_issue_data_o;
    logic                          load_issue_valid_o;
    mem_entry_t                    load_issue_data_o;
    logic                          store_issue_valid_o;
    mem_entry_t                    store_issue_data_o;
    logic                          int_rs1_ready_o;
    logic                          int_rs2_ready_o;
    logic                          load_rs1_ready_o;
    logic                          store_rs1_ready_o;
    logic                          store_rs2_ready_o;

    // Reference state
    int_entry_t           int_q[$];
    mem_entry_t           load_q[$];
    mem_entry_t           store_q[$];
    lq_idx_t              lq_tail_m;
    sq_idx_t              sq_tail_m;
    logic [`PREG_NUM-1:0] busy_m;
    logic                 full_m;
    int                   errors;
    int                   checks;
    int                   tests;

    dispatch_top i_dispatch_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_eq(string name, logic [63:0] exp, logic [63:0] got);
        checks++;
        assert (exp === got) else begin
            $display("Fail %s exp %0h got %0h", name, exp, got);
            errors++;
        end
    endtask

    // **********************************************************************
    // Output checks and reference update, once per cycle
    // **********************************************************************
    task automatic check_outputs();
        full_m = (int_q.size() > `INT_DEPTH - `DIS_WIDTH) ||
                 (load_q.size() > `MEM_DEPTH - `DIS_WIDTH) ||
                 (store_q.size() > `MEM_DEPTH - `DIS_WIDTH);
        check_eq("full_o", 64'(full_m), 64'(full_o));
        check_eq("int_issue_valid_o", 64'(int_q.size() != 0 && !int_issue_full_i),
                 64'(int_issue_valid_o));
        check_eq("load_issue_valid_o", 64'(load_q.size() != 0 && !load_issue_full_i),
                 64'(load_issue_valid_o));
        check_eq("store_issue_valid_o", 64'(store_q.size() != 0 && !store_issue_full_i),
                 64'(store_issue_valid_o));
        if (int_q.size() != 0) begin
            check_eq("int_issue_data_o", 64'(int_q[0]), 64'(int_issue_data_o));
            check_eq("int_rs1_ready_o", 64'(!busy_m[int_q[0].prs1]), 64'(int_rs1_ready_o));
            check_eq("int_rs2_ready_o", 64'(!busy_m[int_q[0].prs2]), 64'(int_rs2_ready_o));
        end
        if (load_q.size() != 0) begin
            check_eq("load_issue_data_o", 64'(load_q[0]), 64'(load_issue_data_o));
            check_eq("load_rs1_ready_o", 64'(!busy_m[load_q[0].prs1]), 64'(load_rs1_ready_o));
        end
        if (store_q.size() != 0) begin
            check_eq("store_issue_data_o", 64'(store_q[0]), 64'(store_issue_data_o));
            check_eq("store_rs1_ready_o", 64'(!busy_m[store_q[0].prs1]),
                     64'(store_rs1_ready_o));
            check_eq("store_rs2_ready_o", 64'(!busy_m[store_q[0].prs2]),
                     64'(store_rs2_ready_o));
        end
    endtask

    task automatic update_models();
        lq_idx_t              lq_cur;
        sq_idx_t              sq_cur;
        int_entry_t           ie;
        mem_entry_t           me;
        logic [`OP_W-1:0]     raw;
        logic [`PREG_NUM-1:0] busy_n;
        if (int_q.size() != 0 && !int_issue_full_i) void'(int_q.pop_front());
        if (load_q.size() != 0 && !load_issue_full_i) void'(load_q.pop_front());
        if (store_q.size() != 0 && !store_issue_full_i) void'(store_q.pop_front());
        busy_n = busy_m;
        for (int w = 0; w < `WAKEUP_NUM; w++) begin
            if (wakeup_valid_i[w]) busy_n[wakeup_preg_i[w]] = 1'b0;
        end
        if (flush_i) begin
            int_q.delete();
            load_q.delete();
            store_q.delete();
            lq_tail_m = lq_restore_i;
            sq_tail_m = sq_restore_i;
        end else if (!full_m) begin
            lq_cur = lq_tail_m;
            sq_cur = sq_tail_m;
            for (int i = 0; i < `DIS_WIDTH; i++) begin
                if (rename_valid_i[i]) begin
                    raw = rename_op_i[i];
                    if (!rename_mem_i[i]) begin
                        ie.robidx = rename_robidx_i[i];
                        ie.prs1   = rename_prs1_i[i];
                        ie.prs2   = rename_prs2_i[i];
                        ie.prd    = rename_prd_i[i];
                        ie.we     = rename_we_i[i];
                        ie.intop  = raw[19:16];
                        ie.imm    = raw[15:0];
                        int_q.push_back(ie);
                    end else begin
                        me.robidx = rename_robidx_i[i];
                        me.prs1   = rename_prs1_i[i];
                        me.prs2   = rename_prs2_i[i];
                        me.prd    = rename_prd_i[i];
                        me.we     = rename_we_i[i];
                        me.memop  = raw[19:17];
                        me.offset = raw[16:5];
                        me.lq_idx = lq_cur;
                        me.sq_idx = sq_cur;
                        // Top memop bit set means store
                        if (raw[19]) begin
                            store_q.push_back(me);
                            sq_cur++;
                        end else begin
                            load_q.push_back(me);
                            lq_cur++;
                        end
                    end
                    if (rename_we_i[i]) busy_n[rename_prd_i[i]] = 1'b1;
                end
            end
            lq_tail_m = lq_cur;
            sq_tail_m = sq_cur;
        end
        busy_m = busy_n;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_outputs();
            update_models();
        end
    end

    // **********************************************************************
    // Stimulus
    // **********************************************************************
    task automatic next_cycle();
        @(posedge clk);
        #1;
        rename_valid_i = '0;
        flush_i        = 1'b0;
        wakeup_valid_i = '0;
    endtask

    task automatic set_issue_full(logic int_full, logic load_full, logic store_full);
        int_issue_full_i   = int_full;
        load_issue_full_i  = load_full;
        store_issue_full_i = store_full;
    endtask

    task automatic offer_random_group();
        for (int i = 0; i < `DIS_WIDTH; i++) begin
            rename_valid_i[i]  = ($urandom_range(0, 3) != 0) && !full_o;
            rename_mem_i[i]    = 1'($urandom_range(0, 1));
            rename_we_i[i]     = 1'($urandom_range(0, 1));
            rename_op_i[i]     = 20'($urandom);
            rename_prs1_i[i]   = 5'($urandom_range(0, 7));
            rename_prs2_i[i]   = 5'($urandom_range(0, 7));
            rename_prd_i[i]    = 5'($urandom_range(0, 7));
            rename_robidx_i[i] = 6'($urandom);
        end
        for (int w = 0; w < `WAKEUP_NUM; w++) begin
            wakeup_valid_i[w] = ($urandom_range(0, 2) == 0);
            wakeup_preg_i[w]  = 5'($urandom_range(0, 7));
        end
    endtask

    task automatic drain(int max_cycles);
        int n;
        set_issue_full(1'b0, 1'b0, 1'b0);
        n = 0;
        while (int_q.size() + load_q.size() + store_q.size() != 0 && n < max_cycles) begin
            next_cycle();
            n++;
        end
        checks++;
        assert (int_q.size() + load_q.size() + store_q.size() == 0) else begin
            $display("Queues still hold ops after %0d drain cycles", max_cycles);
            errors++;
        end
    endtask

    task automatic report_test(string name, int errors_before);
        tests++;
        $display("Test %s finished with %0d errors", name, errors - errors_before);
    endtask

    task automatic run_readiness();
        set_issue_full(1'b1, 1'b1, 1'b1);
        // A load writes p20, then an int op reads p20 and p21
        rename_valid_i  = 2'b11;
        rename_mem_i    = 2'b01;
        rename_we_i     = 2'b01;
        rename_op_i[0]  = 20'h0_1230;
        rename_prd_i[0] = 5'd20;
        rename_prs1_i[1] = 5'd20;
        rename_prs2_i[1] = 5'd21;
        next_cycle();
        repeat (3) next_cycle();
        // Wake p20 while an int op sets p21 and p21 is woken too
        rename_valid_i    = 2'b01;
        rename_mem_i      = 2'b00;
        rename_we_i       = 2'b01;
        rename_prd_i[0]   = 5'd21;
        wakeup_valid_i    = 2'b11;
        wakeup_preg_i[0]  = 5'd20;
        wakeup_preg_i[1]  = 5'd21;
        next_cycle();
        next_cycle();
        wakeup_valid_i   = 2'b01;
        wakeup_preg_i[0] = 5'd21;
        next_cycle();
        next_cycle();
        drain(20);
    endtask

    initial begin
        int err_start;
        void'($urandom(36));
        rst             = 1'b1;
        rename_valid_i  = '0;
        rename_mem_i    = '0;
        rename_we_i     = '0;
        rename_op_i     = '0;
        rename_prs1_i   = '0;
        rename_prs2_i   = '0;
        rename_prd_i    = '0;
        rename_robidx_i = '0;
        flush_i         = 1'b0;
        lq_restore_i    = '0;
        sq_restore_i    = '0;
        wakeup_valid_i  = '0;
        wakeup_preg_i   = '0;
        set_issue_full(1'b0, 1'b0, 1'b0);
        lq_tail_m = '0;
        sq_tail_m = '0;
        busy_m    = '0;
        full_m    = 1'b0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;

        err_start = errors;
        repeat (300) begin
            set_issue_full($urandom_range(0, 3) == 0, $urandom_range(0, 3) == 0,
                           $urandom_range(0, 3) == 0);
            offer_random_group();
            next_cycle();
        end
        drain(40);
        report_test("steering", err_start);

        err_start = errors;
        run_readiness();
        report_test("readiness", err_start);

        err_start = errors;
        set_issue_full(1'b1, 1'b1, 1'b1);
        repeat (12) begin
            offer_random_group();
            next_cycle();
        end
        drain(60);
        report_test("backpressure", err_start);

        err_start = errors;
        set_issue_full(1'b1, 1'b1, 1'b1);
        repeat (4) begin
            offer_random_group();
            next_cycle();
        end
        // Ops offered alongside the flush are dropped
        offer_random_group();
        flush_i      = 1'b1;
        lq_restore_i = 4'($urandom);
        sq_restore_i = 4'($urandom);
        next_cycle();
        set_issue_full(1'b0, 1'b0, 1'b0);
        repeat (3) next_cycle();
        repeat (20) begin
            offer_random_group();
            next_cycle();
        end
        drain(60);
        report_test("flush", err_start);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(CYCLE_BUDGET * 4 + 400);
        $display("Watchdog expired before the tests completed");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+logic
logic/dispatch_pkg.sv
logic/dispatch_ctrl.sv
logic/dispatch_queue.sv
logic/busy_table.sv
logic/dispatch_top.sv
sim/dispatch_properties.sv
sim/dispatch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f --top-module dispatch_tb -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/Vdispatch_tb); then
    echo "$out"
    echo "Simulation exited with an error"
    exit 1
fi
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
